// File: rtl/pmu_consts.svh
`ifndef PMU_CONSTS_SVH
`define PMU_CONSTS_SVH

// datapath widths
`define PMU_CTR_W       64
`define PMU_FETCH_W     32
`define PMU_ADDR_W      5

// bank sizes
`define PMU_NUM_CLASS   6
`define PMU_NUM_TRAFFIC 2

// rv32 major opcodes, bits [6:0]
`define RV_OP_LOAD      7'b0000011
`define RV_OP_STORE     7'b0100011
`define RV_OP_BRANCH    7'b1100011
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_IMM       7'b0010011
`define RV_OP_REG       7'b0110011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_SYSTEM    7'b1110011

`endif

// File: rtl/rv_inst_pkg.sv
package rv_inst_pkg;

    // coarse class of a fetched instruction
    // the encoding doubles as the counter index in each class bank
    typedef enum logic [2:0] {
        ALU    = 3'd0,  // op-imm, op, lui, auipc
        BRANCH = 3'd1,  // branch, jal, jalr
        CSR    = 3'd2,  // system opcode
        LOAD   = 3'd3,
        STORE  = 3'd4,
        OTHER  = 3'd5   // fence, amo, illegal ...
    } inst_class_t;

endpackage

// File: rtl/pmu_map_pkg.sv
`include "pmu_consts.svh"

package pmu_map_pkg;

    // memory traffic events, index into the traffic bank
    typedef enum logic [0:0] {
        FETCH_BEAT = 1'b0,
        LSU_READ   = 1'b1
    } traffic_t;

    // readable counter addresses, anything above CYC_OTHER reads zero
    typedef enum logic [`PMU_ADDR_W-1:0] {
        CYCLES       = 5'd0,
        FETCHES      = 5'd1,
        LSU_READS    = 5'd2,
        FETCH_ALU    = 5'd3,    // fetch counts, class order
        FETCH_BRANCH = 5'd4,
        FETCH_CSR    = 5'd5,
        FETCH_LOAD   = 5'd6,
        FETCH_STORE  = 5'd7,
        FETCH_OTHER  = 5'd8,
        CYC_ALU      = 5'd9,    // cycle counts, class order
        CYC_BRANCH   = 5'd10,
        CYC_CSR      = 5'd11,
        CYC_LOAD     = 5'd12,
        CYC_STORE    = 5'd13,
        CYC_OTHER    = 5'd14
    } ctr_addr_t;

endpackage

// File: rtl/pmu_counter_bank.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module pmu_counter_bank #(
    parameter int  N     = 2,
    parameter type idx_t = logic [0:0]
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [N-1:0]          inc,
    input  idx_t                  rd_idx,
    output logic [`PMU_CTR_W-1:0] rd_data
);

    logic [`PMU_CTR_W-1:0] ctr [N];

    // entries count independently, any number per cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                ctr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < N; i++) begin
                if (inc[i]) begin
                    ctr[i] <= ctr[i] + `PMU_CTR_W'(1);
                end
            end
        end
    end

    assign rd_data = ctr[rd_idx];   // read before this edge's update

    // readout must only steer into populated entries
    a_rd_idx_range: assert property (
        @(posedge clk) disable iff (!rst_n)
        int'(rd_idx) < N
    );

endmodule

// File: rtl/pmu_fetch_profiler.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module pmu_fetch_profiler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_rvalid,
    input  logic                     fetch_rready,
    input  logic [`PMU_FETCH_W-1:0]  fetch_rdata,
    input  logic                     lsu_rvalid,
    input  logic                     lsu_rready,
    input  rv_inst_pkg::inst_class_t class_rd_idx,
    input  pmu_map_pkg::traffic_t    traffic_rd_idx,
    output logic                     fetch_fire,
    output rv_inst_pkg::inst_class_t fetch_class,
    output logic [`PMU_CTR_W-1:0]    class_fetch_data,
    output logic [`PMU_CTR_W-1:0]    traffic_data
);

    logic [`PMU_NUM_CLASS-1:0]   class_inc;
    logic [`PMU_NUM_TRAFFIC-1:0] traffic_inc;

    assign fetch_fire = fetch_rvalid & fetch_rready;

    always_comb begin
        case (fetch_rdata[6:0])
            `RV_OP_IMM, `RV_OP_REG, `RV_OP_LUI, `RV_OP_AUIPC:
                fetch_class = rv_inst_pkg::ALU;
            `RV_OP_BRANCH, `RV_OP_JAL, `RV_OP_JALR:
                fetch_class = rv_inst_pkg::BRANCH;
            `RV_OP_SYSTEM:
                fetch_class = rv_inst_pkg::CSR;
            `RV_OP_LOAD:
                fetch_class = rv_inst_pkg::LOAD;
            `RV_OP_STORE:
                fetch_class = rv_inst_pkg::STORE;
            default:
                fetch_class = rv_inst_pkg::OTHER;
        endcase
    end

    always_comb begin
        class_inc = '0;
        if (fetch_fire) begin
            class_inc[fetch_class] = 1'b1;  // one-hot on the decoded class
        end
    end

    always_comb begin
        traffic_inc = '0;
        traffic_inc[pmu_map_pkg::FETCH_BEAT] = fetch_fire;
        traffic_inc[pmu_map_pkg::LSU_READ]   = lsu_rvalid & lsu_rready;
    end

    pmu_counter_bank #(
        .N     (`PMU_NUM_CLASS),
        .idx_t (rv_inst_pkg::inst_class_t)
    ) i_class_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc     (class_inc),
        .rd_idx  (class_rd_idx),
        .rd_data (class_fetch_data)
    );

    pmu_counter_bank #(
        .N     (`PMU_NUM_TRAFFIC),
        .idx_t (pmu_map_pkg::traffic_t)
    ) i_traffic_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc     (traffic_inc),
        .rd_idx  (traffic_rd_idx),
        .rd_data (traffic_data)
    );

endmodule

// File: rtl/pmu_cycle_profiler.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module pmu_cycle_profiler (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     fetch_fire,
    input  rv_inst_pkg::inst_class_t fetch_class,
    input  logic                     ins_retire,
    input  rv_inst_pkg::inst_class_t class_rd_idx,
    output logic [`PMU_CTR_W-1:0]    class_cycle_data,
    output logic [`PMU_CTR_W-1:0]    cycle_total
);

    rv_inst_pkg::inst_class_t  cur_class;
    logic                      idle;
    logic [`PMU_NUM_CLASS-1:0] cyc_inc;

    // class owns cycles from its fetch up to the next retire
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_class <= rv_inst_pkg::ALU;
            idle      <= 1'b1;
        end else if (fetch_fire) begin
            cur_class <= fetch_class;   // fetch wins over retire
            idle      <= 1'b0;
        end else if (ins_retire) begin
            idle      <= 1'b1;
        end
    end

    always_comb begin
        cyc_inc = '0;
        if (!idle) begin
            cyc_inc[cur_class] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cycle_total <= '0;
        end else begin
            cycle_total <= cycle_total + `PMU_CTR_W'(1);
        end
    end

    pmu_counter_bank #(
        .N     (`PMU_NUM_CLASS),
        .idx_t (rv_inst_pkg::inst_class_t)
    ) i_cycle_bank (
        .clk     (clk),
        .rst_n   (rst_n),
        .inc     (cyc_inc),
        .rd_idx  (class_rd_idx),
        .rd_data (class_cycle_data)
    );

    // a fetch always starts attribution on the next cycle
    a_fire_leaves_idle: assert property (
        @(posedge clk) disable iff (!rst_n)
        fetch_fire |=> !idle
    );

endmodule

// File: rtl/pmu_readout.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module pmu_readout (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rd_en,
    input  pmu_map_pkg::ctr_addr_t   rd_addr,
    input  logic [`PMU_CTR_W-1:0]    class_fetch_data,
    input  logic [`PMU_CTR_W-1:0]    traffic_data,
    input  logic [`PMU_CTR_W-1:0]    class_cycle_data,
    input  logic [`PMU_CTR_W-1:0]    cycle_total,
    output rv_inst_pkg::inst_class_t class_rd_idx,
    output pmu_map_pkg::traffic_t    traffic_rd_idx,
    output logic                     rd_valid,
    output logic [`PMU_CTR_W-1:0]    rd_data
);

    localparam int CLS_W = $bits(rv_inst_pkg::inst_class_t);

    typedef enum logic [2:0] {
        SRC_NONE,
        SRC_TOTAL,
        SRC_TRAFFIC,
        SRC_CLS_FETCH,
        SRC_CLS_CYCLE
    } src_t;

    src_t                  src;
    logic [`PMU_ADDR_W-1:0] addr;
    logic [`PMU_ADDR_W-1:0] fetch_off;
    logic [`PMU_ADDR_W-1:0] cyc_off;
    logic [`PMU_CTR_W-1:0]  sel_data;

    assign addr      = rd_addr;
    assign fetch_off = addr - `PMU_ADDR_W'(pmu_map_pkg::FETCH_ALU);
    assign cyc_off   = addr - `PMU_ADDR_W'(pmu_map_pkg::CYC_ALU);

    // indices idle at entry 0 so the banks never see an empty slot
    always_comb begin
        src            = SRC_NONE;
        class_rd_idx   = rv_inst_pkg::ALU;
        traffic_rd_idx = pmu_map_pkg::FETCH_BEAT;
        if (rd_addr == pmu_map_pkg::CYCLES) begin
            src = SRC_TOTAL;
        end else if (rd_addr == pmu_map_pkg::FETCHES) begin
            src = SRC_TRAFFIC;
        end else if (rd_addr == pmu_map_pkg::LSU_READS) begin
            src            = SRC_TRAFFIC;
            traffic_rd_idx = pmu_map_pkg::LSU_READ;
        end else if (addr >= pmu_map_pkg::FETCH_ALU && addr <= pmu_map_pkg::FETCH_OTHER) begin
            src          = SRC_CLS_FETCH;
            class_rd_idx = rv_inst_pkg::inst_class_t'(fetch_off[CLS_W-1:0]);
        end else if (addr >= pmu_map_pkg::CYC_ALU && addr <= pmu_map_pkg::CYC_OTHER) begin
            src          = SRC_CLS_CYCLE;
            class_rd_idx = rv_inst_pkg::inst_class_t'(cyc_off[CLS_W-1:0]);
        end
    end

    always_comb begin
        case (src)
            SRC_TOTAL:     sel_data = cycle_total;
            SRC_TRAFFIC:   sel_data = traffic_data;
            SRC_CLS_FETCH: sel_data = class_fetch_data;
            SRC_CLS_CYCLE: sel_data = class_cycle_data;
            default:       sel_data = '0;   // unmapped
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= sel_data;    // pre-update snapshot
        end
    end

    a_valid_follows_strobe: assert property (
        @(posedge clk) disable iff (!rst_n)
        rd_valid |-> $past(rd_en)
    );

endmodule

// File: rtl/pmu_top.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module pmu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fetch_rvalid,
    input  logic                    fetch_rready,
    input  logic [`PMU_FETCH_W-1:0] fetch_rdata,
    input  logic                    lsu_rvalid,
    input  logic                    lsu_rready,
    input  logic                    ins_retire,
    input  logic                    rd_en,
    input  pmu_map_pkg::ctr_addr_t  rd_addr,
    output logic                    rd_valid,
    output logic [`PMU_CTR_W-1:0]   rd_data
);

    logic                     fetch_fire;
    rv_inst_pkg::inst_class_t fetch_class;
    rv_inst_pkg::inst_class_t class_rd_idx;
    pmu_map_pkg::traffic_t    traffic_rd_idx;
    logic [`PMU_CTR_W-1:0]    class_fetch_data;
    logic [`PMU_CTR_W-1:0]    traffic_data;
    logic [`PMU_CTR_W-1:0]    class_cycle_data;
    logic [`PMU_CTR_W-1:0]    cycle_total;

    pmu_fetch_profiler i_fetch_prof (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_rvalid     (fetch_rvalid),
        .fetch_rready     (fetch_rready),
        .fetch_rdata      (fetch_rdata),
        .lsu_rvalid       (lsu_rvalid),
        .lsu_rready       (lsu_rready),
        .class_rd_idx     (class_rd_idx),
        .traffic_rd_idx   (traffic_rd_idx),
        .fetch_fire       (fetch_fire),
        .fetch_class      (fetch_class),
        .class_fetch_data (class_fetch_data),
        .traffic_data     (traffic_data)
    );

    pmu_cycle_profiler i_cycle_prof (
        .clk              (clk),
        .rst_n            (rst_n),
        .fetch_fire       (fetch_fire),
        .fetch_class      (fetch_class),
        .ins_retire       (ins_retire),
        .class_rd_idx     (class_rd_idx),
        .class_cycle_data (class_cycle_data),
        .cycle_total      (cycle_total)
    );

    pmu_readout i_readout (
        .clk              (clk),
        .rst_n            (rst_n),
        .rd_en            (rd_en),
        .rd_addr          (rd_addr),
        .class_fetch_data (class_fetch_data),
        .traffic_data     (traffic_data),
        .class_cycle_data (class_cycle_data),
        .cycle_total      (cycle_total),
        .class_rd_idx     (class_rd_idx),
        .traffic_rd_idx   (traffic_rd_idx),
        .rd_valid         (rd_valid),
        .rd_data          (rd_data)
    );

endmodule

// File: test/tb_pmu_top.sv
`timescale 1ns/1ps
`include "pmu_consts.svh"

module tb_pmu_top;

    localparam int TIMEOUT = 20;
    localparam logic [6:0] OPCODES [10] = '{
        `RV_OP_LOAD, `RV_OP_STORE, `RV_OP_BRANCH, `RV_OP_JAL, `RV_OP_JALR,
        `RV_OP_IMM, `RV_OP_REG, `RV_OP_LUI, `RV_OP_AUIPC, `RV_OP_SYSTEM
    };

    logic                    clk;
    logic                    rst_n;
    logic                    fetch_rvalid;
    logic                    fetch_rready;
    logic [`PMU_FETCH_W-1:0] fetch_rdata;
    logic                    lsu_rvalid;
    logic                    lsu_rready;
    logic                    ins_retire;
    logic                    rd_en;
    pmu_map_pkg::ctr_addr_t  rd_addr;
    logic                    rd_valid;
    logic [`PMU_CTR_W-1:0]   rd_data;

    logic [31:0] lfsr_state;
    logic        traffic_on;

    // reference counters
    logic [`PMU_CTR_W-1:0] m_cycles;
    logic [`PMU_CTR_W-1:0] m_fetches;
    logic [`PMU_CTR_W-1:0] m_lsu;
    logic [`PMU_CTR_W-1:0] m_cls_fetch [6];
    logic [`PMU_CTR_W-1:0] m_cls_cyc [6];
    logic                  m_idle;
    int                    m_class;
    int                    m_dec;
    logic [`PMU_CTR_W-1:0] exp_q [$];
    int                    addr_q [$];

    int checks;
    int errors;
    int test_errors;
    int tests_run;
    int tests_failed;

    pmu_top i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_rvalid (fetch_rvalid),
        .fetch_rready (fetch_rready),
        .fetch_rdata  (fetch_rdata),
        .lsu_rvalid   (lsu_rvalid),
        .lsu_rready   (lsu_rready),
        .ins_retire   (ins_retire),
        .rd_en        (rd_en),
        .rd_addr      (rd_addr),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // index order alu branch csr load store other
    function automatic int decode_class(input logic [6:0] op);
        case (op)
            `RV_OP_IMM, `RV_OP_REG, `RV_OP_LUI, `RV_OP_AUIPC: return 0;
            `RV_OP_BRANCH, `RV_OP_JAL, `RV_OP_JALR:           return 1;
            `RV_OP_SYSTEM:                                   return 2;
            `RV_OP_LOAD:                                     return 3;
            `RV_OP_STORE:                                    return 4;
            default:                                         return 5;
        endcase
    endfunction

    function automatic logic [`PMU_CTR_W-1:0] expected_value(input int a);
        if (a == 0) return m_cycles;
        if (a == 1) return m_fetches;
        if (a == 2) return m_lsu;
        if (a >= 3 && a <= 8) return m_cls_fetch[a-3];
        if (a >= 9 && a <= 14) return m_cls_cyc[a-9];
        return '0;  // unmapped
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            m_cycles  = '0;
            m_fetches = '0;
            m_lsu     = '0;
            for (int i = 0; i < 6; i++) begin
                m_cls_fetch[i] = '0;
                m_cls_cyc[i]   = '0;
            end
            m_idle  = 1'b1;
            m_class = 0;
        end else begin
            if (rd_en) begin   // snapshot before this edge's updates
                exp_q.push_back(expected_value(int'(rd_addr)));
                addr_q.push_back(int'(rd_addr));
            end
            m_dec = decode_class(fetch_rdata[6:0]);
            m_cycles = m_cycles + 1;
            if (!m_idle) m_cls_cyc[m_class] = m_cls_cyc[m_class] + 1;
            if (lsu_rvalid && lsu_rready) m_lsu = m_lsu + 1;
            if (fetch_rvalid && fetch_rready) begin
                m_fetches          = m_fetches + 1;
                m_cls_fetch[m_dec] = m_cls_fetch[m_dec] + 1;
                m_class            = m_dec;
                m_idle             = 1'b0;
            end else if (ins_retire) begin
                m_idle = 1'b1;
            end
        end
    end

    task automatic note_error();
        errors++;
        test_errors++;
    endtask

    task automatic quiet_core();
        fetch_rvalid = 1'b0;
        fetch_rready = 1'b0;
        fetch_rdata  = '0;
        lsu_rvalid   = 1'b0;
        lsu_rready   = 1'b0;
        ins_retire   = 1'b0;
    endtask

    task automatic randomize_core();
        logic [3:0] sel;
        sel          = 4'(rand_bits(4));
        fetch_rvalid = 1'(rand_bits(1));
        fetch_rready = 1'(rand_bits(1));
        lsu_rvalid   = 1'(rand_bits(1));
        lsu_rready   = 1'(rand_bits(1));
        ins_retire   = 1'(rand_bits(1));
        if (sel < 10) begin
            fetch_rdata = {25'(rand_bits(25)), OPCODES[sel]};
        end else begin
            fetch_rdata = rand_bits(32);    // raw bytes
        end
    endtask

    task automatic drive_cycle(input logic rd, input int addr);
        if (traffic_on) randomize_core();
        rd_en   = rd;
        rd_addr = pmu_map_pkg::ctr_addr_t'(addr[`PMU_ADDR_W-1:0]);
        @(posedge clk);
        #1;
    endtask

    task automatic await_result();
        int                    waited;
        int                    a;
        logic [`PMU_CTR_W-1:0] exp;
        waited = 0;
        while (!rd_valid && waited < TIMEOUT) begin
            drive_cycle(1'b0, 0);
            waited++;
        end
        if (!rd_valid) begin
            $display("timeout: rd_valid did not rise within %0d cycles of a strobe", TIMEOUT);
            $display("*** FAILED ***");
            $finish;
        end else begin
            checks++;
            if (waited != 0) begin
                $display("rd_valid came %0d cycles later than expected at %0t", waited, $time);
                note_error();
            end
            exp = exp_q.pop_front();
            a   = addr_q.pop_front();
            if (rd_data !== exp) begin
                $display("MISMATCH @ %0t: addr %0d read %h, expected %h",
                         $time, a, rd_data, exp);
                note_error();
            end
        end
    endtask

    task automatic read_counter(input int addr);
        drive_cycle(1'b1, addr);
        await_result();
    endtask

    // single read and rd_valid must drop again
    task automatic read_single(input int addr);
        read_counter(addr);
        drive_cycle(1'b0, 0);
        checks++;
        if (rd_valid !== 1'b0) begin
            $display("rd_valid stayed high for more than one cycle at %0t", $time);
            note_error();
        end
    endtask

    task automatic finish_test(input int num, input string name);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        $display("test %0d %s: %s, %0d errors", num, name,
                 (test_errors == 0) ? "ok" : "bad", test_errors);
        test_errors = 0;
    endtask

    initial begin
        lfsr_state   = 32'hcbc6;
        traffic_on   = 1'b0;
        checks       = 0;
        errors       = 0;
        test_errors  = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst_n        = 1'b0;
        rd_en        = 1'b0;
        rd_addr      = pmu_map_pkg::CYCLES;
        quiet_core();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;

        for (int i = 0; i < 4; i++) begin
            checks++;
            if (rd_valid !== 1'b0) begin
                $display("rd_valid high before the first read strobe at %0t", $time);
                note_error();
            end
            drive_cycle(1'b0, 0);
        end
        for (int a = 0; a < 32; a++) read_single(a);
        finish_test(1, "reset values");

        traffic_on = 1'b1;
        repeat (4) begin
            repeat (50) drive_cycle(1'b0, 0);
            for (int a = 0; a < 3; a++) read_single(a);
        end
        finish_test(2, "traffic counts");

        traffic_on = 1'b0;
        for (int k = 0; k < 11; k++) begin   // every opcode and then one raw word
            quiet_core();
            fetch_rvalid = 1'b1;
            fetch_rready = 1'b1;
            fetch_rdata  = (k < 10) ? {25'(rand_bits(25)), OPCODES[k]} : rand_bits(32);
            drive_cycle(1'b0, 0);
        end
        traffic_on = 1'b1;
        repeat (100) drive_cycle(1'b0, 0);
        traffic_on = 1'b0;
        quiet_core();
        for (int a = 3; a < 9; a++) read_single(a);
        finish_test(3, "class fetch counts");

        ins_retire = 1'b1;
        repeat (2) drive_cycle(1'b0, 0);    // second retire lands while idle
        fetch_rvalid = 1'b1;
        fetch_rready = 1'b1;
        fetch_rdata  = {25'(rand_bits(25)), `RV_OP_SYSTEM};
        drive_cycle(1'b0, 0);               // fetch and retire together
        quiet_core();
        repeat (3) drive_cycle(1'b0, 0);
        ins_retire = 1'b1;
        drive_cycle(1'b0, 0);
        quiet_core();
        repeat (2) drive_cycle(1'b0, 0);
        traffic_on = 1'b1;
        repeat (150) drive_cycle(1'b0, 0);
        traffic_on = 1'b0;
        quiet_core();
        for (int a = 9; a < 15; a++) read_single(a);
        finish_test(4, "class cycle counts");

        traffic_on = 1'b1;
        repeat (40) drive_cycle(1'b0, 0);
        for (int a = 0; a < 32; a++) read_counter(a);
        drive_cycle(1'b0, 0);
        checks++;
        if (rd_valid !== 1'b0) begin
            $display("rd_valid still high after the last strobe at %0t", $time);
            note_error();
        end
        traffic_on = 1'b0;
        quiet_core();
        finish_test(5, "back-to-back reads");

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+rtl
rtl/rv_inst_pkg.sv
rtl/pmu_map_pkg.sv
rtl/pmu_counter_bank.sv
rtl/pmu_fetch_profiler.sv
rtl/pmu_cycle_profiler.sv
rtl/pmu_readout.sv
rtl/pmu_top.sv
test/tb_pmu_top.sv

// File: Bender.yml
package:
  name: pmu

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/rv_inst_pkg.sv
      - rtl/pmu_map_pkg.sv
      - rtl/pmu_counter_bank.sv
      - rtl/pmu_fetch_profiler.sv
      - rtl/pmu_cycle_profiler.sv
      - rtl/pmu_readout.sv
      - rtl/pmu_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_pmu_top.sv
